//--- common/pcie_user_params.svh
// PCIe user interface constants
`ifndef PCIE_USER_PARAMS_SVH
`define PCIE_USER_PARAMS_SVH

// Stream and FIFO word
`define PCIE_DATA_W 32
`define PCIE_KEEP_W 4

// Buffer size and word count
`define PCIE_COUNT_W 24

// Address bits of one ping-pong buffer
`define CONTROL_FIFO_AW 5
`define DATA_FIFO_AW 7

// Function select values
`define CONTROL_FUNCTION_ID 1'b0
`define DATA_FUNCTION_ID 1'b1

`endif

//--- common/pcie_user_pkg.sv
// PCIe user interface types
`default_nettype none

`include "pcie_user_params.svh"

package pcie_user_pkg;

  // One stream beat, valid and ready travel beside it
  typedef struct packed {
    logic [`PCIE_DATA_W-1:0] data;
    logic [`PCIE_KEEP_W-1:0] keep;
    logic                    last;
  } axis_beat_t;

  // Ping-pong write port, writer side
  typedef struct packed {
    logic [1:0]              activate;
    logic                    stb;
    logic [`PCIE_DATA_W-1:0] data;
  } ppfifo_wr_req_t;

  // Ping-pong write port, FIFO side
  typedef struct packed {
    logic [1:0]               ready;
    logic [`PCIE_COUNT_W-1:0] size;
  } ppfifo_wr_rsp_t;

  // Ping-pong read port, reader side
  typedef struct packed {
    logic activate;
    logic stb;
  } ppfifo_rd_req_t;

  // Ping-pong read port, FIFO side
  typedef struct packed {
    logic                     ready;
    logic [`PCIE_COUNT_W-1:0] count;
    logic [`PCIE_DATA_W-1:0]  data;
  } ppfifo_rd_rsp_t;

endpackage

`default_nettype wire

//--- hdl/axis_to_ppfifo.sv
// AXI stream to ping-pong FIFO writer
`timescale 1ns/1ps
`default_nettype none

`include "pcie_user_params.svh"

module axis_to_ppfifo import pcie_user_pkg::*; (
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  logic           i_valid,
  input  axis_beat_t     i_beat,
  output logic           o_ready,
  output ppfifo_wr_req_t o_wr,
  input  ppfifo_wr_rsp_t i_wr
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STREAM,
    ST_RELEASE
  } state_t;

  state_t                   state;
  logic [1:0]               wr_act;
  logic [`PCIE_COUNT_W-1:0] word_cnt;
  logic                     accept;
  logic                     buf_full;

  assign o_ready = (state == ST_STREAM);
  assign accept  = i_valid && o_ready;

  // This beat takes the last free slot
  assign buf_full = ((word_cnt + 1'b1) == i_wr.size);

  // One FIFO strobe per accepted beat, keep is dropped
  assign o_wr.activate = wr_act;
  assign o_wr.stb      = accept;
  assign o_wr.data     = i_beat.data;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state    <= ST_IDLE;
      wr_act   <= 2'b00;
      word_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_wr.ready[0]) begin
            wr_act   <= 2'b01;
            word_cnt <= '0;
            state    <= ST_STREAM;
          end else if (i_wr.ready[1]) begin
            wr_act   <= 2'b10;
            word_cnt <= '0;
            state    <= ST_STREAM;
          end
        end
        ST_STREAM: begin
          if (accept) begin
            word_cnt <= word_cnt + 1'b1;
            if (i_beat.last || buf_full) begin
              // Dropping activate commits the buffer
              wr_act <= 2'b00;
              state  <= ST_RELEASE;
            end
          end
        end
        ST_RELEASE: begin
          // Let the FIFO update its ready bits before the next claim
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/function_steer.sv
// Function select stream steering
`timescale 1ns/1ps
`default_nettype none

`include "pcie_user_params.svh"

module function_steer import pcie_user_pkg::*; (
  input  logic       i_function_sel,
  input  logic       i_rx_valid,
  input  axis_beat_t i_rx_beat,
  output logic       o_rx_ready,
  output logic       o_ctl_in_valid,
  output axis_beat_t o_ctl_in_beat,
  input  logic       i_ctl_in_ready,
  output logic       o_dat_in_valid,
  output axis_beat_t o_dat_in_beat,
  input  logic       i_dat_in_ready,
  input  logic       i_ctl_out_valid,
  input  axis_beat_t i_ctl_out_beat,
  output logic       o_ctl_out_ready,
  input  logic       i_dat_out_valid,
  input  axis_beat_t i_dat_out_beat,
  output logic       o_dat_out_ready,
  output logic       o_tx_valid,
  output axis_beat_t o_tx_beat,
  input  logic       i_tx_ready
);

  logic ctl_sel;
  logic dat_sel;

  assign ctl_sel = (i_function_sel == `CONTROL_FUNCTION_ID);
  assign dat_sel = (i_function_sel == `DATA_FUNCTION_ID);

  // Receive side, unselected path sees an idle stream
  assign o_ctl_in_valid = ctl_sel && i_rx_valid;
  assign o_dat_in_valid = dat_sel && i_rx_valid;
  assign o_ctl_in_beat  = ctl_sel ? i_rx_beat : '0;
  assign o_dat_in_beat  = dat_sel ? i_rx_beat : '0;
  assign o_rx_ready     = (ctl_sel && i_ctl_in_ready) || (dat_sel && i_dat_in_ready);

  // Transmit side
  assign o_ctl_out_ready = ctl_sel && i_tx_ready;
  assign o_dat_out_ready = dat_sel && i_tx_ready;
  assign o_tx_valid      = ctl_sel ? i_ctl_out_valid : i_dat_out_valid;
  assign o_tx_beat       = ctl_sel ? i_ctl_out_beat : i_dat_out_beat;

endmodule

`default_nettype wire

//--- hdl/pcie_user_interface.sv
// PCIe user side interface
`timescale 1ns/1ps
`default_nettype none

`include "pcie_user_params.svh"

module pcie_user_interface import pcie_user_pkg::*; (
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  logic           i_function_sel,
  input  logic           i_rx_valid,
  input  axis_beat_t     i_rx_beat,
  output logic           o_rx_ready,
  output logic           o_tx_valid,
  output axis_beat_t     o_tx_beat,
  input  logic           i_tx_ready,
  input  ppfifo_rd_req_t i_cmd_in_rd,
  output ppfifo_rd_rsp_t o_cmd_in_rd,
  input  ppfifo_wr_req_t i_cmd_out_wr,
  output ppfifo_wr_rsp_t o_cmd_out_wr,
  input  ppfifo_rd_req_t i_data_in_rd,
  output ppfifo_rd_rsp_t o_data_in_rd,
  input  ppfifo_wr_req_t i_data_out_wr,
  output ppfifo_wr_rsp_t o_data_out_wr
);

  // Streams between steering and adapters
  logic           ctl_in_valid;
  axis_beat_t     ctl_in_beat;
  logic           ctl_in_ready;
  logic           dat_in_valid;
  axis_beat_t     dat_in_beat;
  logic           dat_in_ready;
  logic           ctl_out_valid;
  axis_beat_t     ctl_out_beat;
  logic           ctl_out_ready;
  logic           dat_out_valid;
  axis_beat_t     dat_out_beat;
  logic           dat_out_ready;

  // Adapter side FIFO ports
  ppfifo_wr_req_t ctl_in_wr_req;
  ppfifo_wr_rsp_t ctl_in_wr_rsp;
  ppfifo_wr_req_t dat_in_wr_req;
  ppfifo_wr_rsp_t dat_in_wr_rsp;
  ppfifo_rd_req_t ctl_out_rd_req;
  ppfifo_rd_rsp_t ctl_out_rd_rsp;
  ppfifo_rd_req_t dat_out_rd_req;
  ppfifo_rd_rsp_t dat_out_rd_rsp;

  function_steer u_steer (
    .i_function_sel (i_function_sel), .i_rx_valid     (i_rx_valid),
    .i_rx_beat      (i_rx_beat),      .o_rx_ready     (o_rx_ready),
    .o_ctl_in_valid (ctl_in_valid),   .o_ctl_in_beat  (ctl_in_beat),
    .i_ctl_in_ready (ctl_in_ready),   .o_dat_in_valid (dat_in_valid),
    .o_dat_in_beat  (dat_in_beat),    .i_dat_in_ready (dat_in_ready),
    .i_ctl_out_valid(ctl_out_valid),  .i_ctl_out_beat (ctl_out_beat),
    .o_ctl_out_ready(ctl_out_ready),  .i_dat_out_valid(dat_out_valid),
    .i_dat_out_beat (dat_out_beat),   .o_dat_out_ready(dat_out_ready),
    .o_tx_valid     (o_tx_valid),     .o_tx_beat      (o_tx_beat),
    .i_tx_ready     (i_tx_ready)
  );

  // Control channel
  axis_to_ppfifo u_ctl_a2p (
    .i_clk  (i_clk),        .i_rst_n(i_rst_n),     .i_valid(ctl_in_valid),
    .i_beat (ctl_in_beat),  .o_ready(ctl_in_ready),
    .o_wr   (ctl_in_wr_req), .i_wr  (ctl_in_wr_rsp)
  );

  ppfifo #(.ADDR_W(`CONTROL_FIFO_AW)) u_ctl_ingress (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_wr (ctl_in_wr_req), .o_wr(ctl_in_wr_rsp),
    .i_rd (i_cmd_in_rd),   .o_rd(o_cmd_in_rd)
  );

  ppfifo #(.ADDR_W(`CONTROL_FIFO_AW)) u_ctl_egress (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_wr (i_cmd_out_wr),   .o_wr(o_cmd_out_wr),
    .i_rd (ctl_out_rd_req), .o_rd(ctl_out_rd_rsp)
  );

  ppfifo_to_axis u_ctl_p2a (
    .i_clk  (i_clk),          .i_rst_n(i_rst_n),
    .o_rd   (ctl_out_rd_req), .i_rd   (ctl_out_rd_rsp),
    .o_valid(ctl_out_valid),  .o_beat (ctl_out_beat), .i_ready(ctl_out_ready)
  );

  // Data channel
  axis_to_ppfifo u_dat_a2p (
    .i_clk  (i_clk),        .i_rst_n(i_rst_n),     .i_valid(dat_in_valid),
    .i_beat (dat_in_beat),  .o_ready(dat_in_ready),
    .o_wr   (dat_in_wr_req), .i_wr  (dat_in_wr_rsp)
  );

  ppfifo #(.ADDR_W(`DATA_FIFO_AW)) u_dat_ingress (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_wr (dat_in_wr_req), .o_wr(dat_in_wr_rsp),
    .i_rd (i_data_in_rd),  .o_rd(o_data_in_rd)
  );

  ppfifo #(.ADDR_W(`DATA_FIFO_AW)) u_dat_egress (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_wr (i_data_out_wr),  .o_wr(o_data_out_wr),
    .i_rd (dat_out_rd_req), .o_rd(dat_out_rd_rsp)
  );

  ppfifo_to_axis u_dat_p2a (
    .i_clk  (i_clk),          .i_rst_n(i_rst_n),
    .o_rd   (dat_out_rd_req), .i_rd   (dat_out_rd_rsp),
    .o_valid(dat_out_valid),  .o_beat (dat_out_beat), .i_ready(dat_out_ready)
  );

endmodule

`default_nettype wire

//--- hdl/ppfifo_to_axis.sv
// Ping-pong FIFO reader to AXI stream
`timescale 1ns/1ps
`default_nettype none

`include "pcie_user_params.svh"

module ppfifo_to_axis import pcie_user_pkg::*; (
  input  logic           i_clk,
  input  logic           i_rst_n,
  output ppfifo_rd_req_t o_rd,
  input  ppfifo_rd_rsp_t i_rd,
  output logic           o_valid,
  output axis_beat_t     o_beat,
  input  logic           i_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_LATCH,
    ST_STREAM
  } state_t;

  state_t                   state;
  logic                     rd_act;
  logic [`PCIE_COUNT_W-1:0] count_q;
  logic [`PCIE_COUNT_W-1:0] rd_cnt;
  logic                     out_valid;
  axis_beat_t               beat_q;
  logic                     can_load;

  // Refill when the output register is empty or being taken
  assign can_load = (state == ST_STREAM) && (rd_cnt != count_q) &&
                    (!out_valid || i_ready);

  assign o_rd.activate = rd_act;
  assign o_rd.stb      = can_load;
  assign o_valid       = out_valid;
  assign o_beat        = beat_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state     <= ST_IDLE;
      rd_act    <= 1'b0;
      count_q   <= '0;
      rd_cnt    <= '0;
      out_valid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_rd.ready) begin
            rd_act <= 1'b1;
            state  <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          // FIFO takes the activate at this edge
          rd_cnt <= '0;
          state  <= ST_LATCH;
        end
        ST_LATCH: begin
          count_q <= i_rd.count;
          state   <= ST_STREAM;
        end
        ST_STREAM: begin
          if (can_load) begin
            rd_cnt <= rd_cnt + 1'b1;
          end else if (rd_cnt == count_q) begin
            // Every word is out of the FIFO, release the buffer
            rd_act <= 1'b0;
            state  <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase

      if (can_load) begin
        out_valid <= 1'b1;
      end else if (i_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Output word register
  always_ff @(posedge i_clk) begin
    if (can_load) begin
      beat_q.data <= i_rd.data;
      beat_q.keep <= '1;
      beat_q.last <= (rd_cnt == (count_q - 1'b1));
    end
  end

endmodule

`default_nettype wire

//--- ppfifo/ppfifo.sv
// Ping-pong FIFO
`timescale 1ns/1ps
`default_nettype none

`include "pcie_user_params.svh"

module ppfifo import pcie_user_pkg::*; #(
  parameter int ADDR_W = 5
) (
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  ppfifo_wr_req_t i_wr,
  output ppfifo_wr_rsp_t o_wr,
  input  ppfifo_rd_req_t i_rd,
  output ppfifo_rd_rsp_t o_rd
);

  localparam int DEPTH = 2 ** ADDR_W;
  localparam logic [ADDR_W:0] BUF_FULL = {1'b1, {ADDR_W{1'b0}}};

  typedef enum logic [1:0] {
    BUF_EMPTY,
    BUF_FILLING,
    BUF_COMMITTED,
    BUF_READING
  } buf_state_t;

  buf_state_t              buf_state [2];
  logic [ADDR_W:0]         buf_count [2];
  logic [`PCIE_DATA_W-1:0] mem [2*DEPTH];
  logic                    first_commit;
  logic                    rd_ptr;
  logic [ADDR_W-1:0]       rd_addr;
  logic [`PCIE_DATA_W-1:0] rd_data;
  logic                    wr_buf;
  logic                    wr_en;
  logic                    reading;
  logic                    rd_start;

  // Buffer 0 wins if a writer raises both activates
  assign wr_buf = ~i_wr.activate[0];
  assign wr_en  = i_wr.stb && i_wr.activate[wr_buf] &&
                  (buf_state[wr_buf] == BUF_EMPTY || buf_state[wr_buf] == BUF_FILLING) &&
                  (buf_count[wr_buf] != BUF_FULL);

  assign reading  = (buf_state[rd_ptr] == BUF_READING);
  assign rd_start = i_rd.activate && o_rd.ready;

  assign o_wr.ready = {buf_state[1] == BUF_EMPTY, buf_state[0] == BUF_EMPTY};
  assign o_wr.size  = {{(`PCIE_COUNT_W-ADDR_W-1){1'b0}}, BUF_FULL};

  // Oldest committed buffer is offered only when nothing is being read
  assign o_rd.ready = !reading && (buf_state[first_commit] == BUF_COMMITTED);
  assign o_rd.count = {{(`PCIE_COUNT_W-ADDR_W-1){1'b0}}, buf_count[rd_ptr]};
  assign o_rd.data  = rd_data;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      buf_state[0] <= BUF_EMPTY;
      buf_state[1] <= BUF_EMPTY;
      buf_count[0] <= '0;
      buf_count[1] <= '0;
      first_commit <= 1'b0;
      rd_ptr       <= 1'b0;
      rd_addr      <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        case (buf_state[i])
          BUF_EMPTY: begin
            if (i_wr.activate[i]) begin
              buf_state[i] <= BUF_FILLING;
            end
          end
          BUF_FILLING: begin
            if (!i_wr.activate[i]) begin
              if (buf_count[i] == '0) begin
                // Nothing written, hand it straight back
                buf_state[i] <= BUF_EMPTY;
              end else begin
                buf_state[i] <= BUF_COMMITTED;
                if (buf_state[1-i] != BUF_COMMITTED) begin
                  first_commit <= i[0];
                end
              end
            end
          end
          BUF_COMMITTED: begin
            if (rd_start && first_commit == i[0]) begin
              buf_state[i] <= BUF_READING;
            end
          end
          BUF_READING: begin
            if (!i_rd.activate) begin
              buf_state[i] <= BUF_EMPTY;
              buf_count[i] <= '0;
            end
          end
          default: buf_state[i] <= BUF_EMPTY;
        endcase
      end

      if (wr_en) begin
        buf_count[wr_buf] <= buf_count[wr_buf] + 1'b1;
      end

      // Other buffer becomes the next in line once this one is taken
      if (rd_start) begin
        rd_ptr       <= first_commit;
        first_commit <= ~first_commit;
        rd_addr      <= {{(ADDR_W-1){1'b0}}, 1'b1};
      end else if (reading && i_rd.stb) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // Storage and read register, rd_data holds the current word
  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      mem[{wr_buf, buf_count[wr_buf][ADDR_W-1:0]}] <= i_wr.data;
    end
    if (rd_start) begin
      rd_data <= mem[{first_commit, {ADDR_W{1'b0}}}];
    end else if (reading && i_rd.stb) begin
      rd_data <= mem[{rd_ptr, rd_addr}];
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the PCIe user interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_pcie_user_interface

verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -qx "Verification passed" "$LOG" && [ $sim_status -eq 0 ]; then
  exit 0
fi

echo "Simulation failed with status $sim_status"
exit 1

//--- tests/tb_vectors.svh
// Testbench stimulus table
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Row direction
localparam logic DIR_INGRESS = 1'b0;
localparam logic DIR_EGRESS  = 1'b1;

// Columns are direction, function select, packet length in words, random tx back-pressure
typedef struct packed {
  logic dir;
  logic sel;
  int   len;
  logic bp;
} vector_t;

localparam int NUM_VECTORS = 5;

vector_t vectors [NUM_VECTORS];

task automatic load_vectors();
  vectors[0] = '{DIR_INGRESS, `CONTROL_FUNCTION_ID, 20, 1'b0};
  vectors[1] = '{DIR_INGRESS, `DATA_FUNCTION_ID, 100, 1'b0};
  // Longer than one control buffer
  vectors[2] = '{DIR_INGRESS, `CONTROL_FUNCTION_ID, 50, 1'b0};
  vectors[3] = '{DIR_EGRESS, `CONTROL_FUNCTION_ID, 12, 1'b0};
  vectors[4] = '{DIR_EGRESS, `DATA_FUNCTION_ID, 60, 1'b1};
endtask

`endif

//--- tests/tb_pcie_user_interface.sv
// PCIe user interface testbench
`timescale 1ns/1ps
`default_nettype none

`include "pcie_user_params.svh"

module tb_pcie_user_interface import pcie_user_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int CTL_DEPTH = 1 << `CONTROL_FIFO_AW;
  localparam int DAT_DEPTH = 1 << `DATA_FIFO_AW;

  logic           clk;
  logic           rst_n;
  logic           function_sel;
  logic           rx_valid;
  axis_beat_t     rx_beat;
  logic           rx_ready;
  logic           tx_valid;
  axis_beat_t     tx_beat;
  logic           tx_ready;
  ppfifo_rd_req_t cmd_in_rd;
  ppfifo_rd_rsp_t cmd_in_rsp;
  ppfifo_wr_req_t cmd_out_wr;
  ppfifo_wr_rsp_t cmd_out_rsp;
  ppfifo_rd_req_t data_in_rd;
  ppfifo_rd_rsp_t data_in_rsp;
  ppfifo_wr_req_t data_out_wr;
  ppfifo_wr_rsp_t data_out_rsp;

  logic [31:0]    rng_state;
  logic [31:0]    exp_words [$];
  logic           watch_quiet;
  logic           watch_sel;

  `include "tb_vectors.svh"

  pcie_user_interface DUT (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_function_sel(function_sel),
    .i_rx_valid    (rx_valid),
    .i_rx_beat     (rx_beat),
    .o_rx_ready    (rx_ready),
    .o_tx_valid    (tx_valid),
    .o_tx_beat     (tx_beat),
    .i_tx_ready    (tx_ready),
    .i_cmd_in_rd   (cmd_in_rd),
    .o_cmd_in_rd   (cmd_in_rsp),
    .i_cmd_out_wr  (cmd_out_wr),
    .o_cmd_out_wr  (cmd_out_rsp),
    .i_data_in_rd  (data_in_rd),
    .o_data_in_rd  (data_in_rsp),
    .i_data_out_wr (data_out_wr),
    .o_data_out_wr (data_out_rsp)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out waiting for %s", what);
    abort_run();
  endtask

  task automatic check_beat(input axis_beat_t got, input axis_beat_t exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s got data %h keep %h last %b, expected data %h keep %h last %b",
               $time, what, got.data, got.keep, got.last, exp.data, exp.keep, exp.last);
      abort_run();
    end
  endtask

  task automatic check_rd_rsp(input ppfifo_rd_rsp_t got, input ppfifo_rd_rsp_t exp,
                              input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s got ready %b count %0d data %h, expected ready %b count %0d data %h",
               $time, what, got.ready, got.count, got.data, exp.ready, exp.count, exp.data);
      abort_run();
    end
  endtask

  task automatic check_wr_ready(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_wr_size(input logic [`PCIE_COUNT_W-1:0] got,
                               input logic [`PCIE_COUNT_W-1:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic ppfifo_rd_rsp_t in_rd_rsp(input logic sel);
    return (sel == `CONTROL_FUNCTION_ID) ? cmd_in_rsp : data_in_rsp;
  endfunction

  function automatic ppfifo_wr_rsp_t out_wr_rsp(input logic sel);
    return (sel == `CONTROL_FUNCTION_ID) ? cmd_out_rsp : data_out_rsp;
  endfunction

  task automatic drive_in_rd(input logic sel, input logic act, input logic stb);
    if (sel == `CONTROL_FUNCTION_ID) begin
      cmd_in_rd.activate <= act;
      cmd_in_rd.stb      <= stb;
    end else begin
      data_in_rd.activate <= act;
      data_in_rd.stb      <= stb;
    end
  endtask

  task automatic drive_out_wr(input logic sel, input ppfifo_wr_req_t req);
    if (sel == `CONTROL_FUNCTION_ID) begin
      cmd_out_wr <= req;
    end else begin
      data_out_wr <= req;
    end
  endtask

  // The unselected ingress port must stay idle
  always @(negedge clk) begin
    if (watch_quiet) begin
      if (watch_sel == `CONTROL_FUNCTION_ID) begin
        check_bit(data_in_rsp.ready, 1'b0, "data-in read ready");
      end else begin
        check_bit(cmd_in_rsp.ready, 1'b0, "command-in read ready");
      end
    end
  end

  task automatic send_packet(input int len);
    logic [31:0] word;
    logic        accepted;
    int          sent;
    int          wait_cnt;
    sent = 0;
    wait_cnt = 0;
    word = next_random();
    exp_words.push_back(word);
    @(posedge clk);
    rx_valid <= 1'b1;
    rx_beat  <= '{data: word, keep: 4'hF, last: (len == 1)};
    while (sent < len) begin
      @(negedge clk);
      accepted = rx_ready;
      if (accepted) begin
        sent++;
        wait_cnt = 0;
      end else begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT_CYCLES) begin
          timeout_fail("receive stream ready");
        end
      end
      @(posedge clk);
      if (accepted && sent == len) begin
        rx_valid <= 1'b0;
      end else if (accepted) begin
        word = next_random();
        exp_words.push_back(word);
        rx_beat <= '{data: word, keep: 4'hF, last: (sent == len - 1)};
      end
    end
  endtask

  task automatic read_buffer(input logic sel, input int n);
    ppfifo_rd_rsp_t           rsp;
    ppfifo_rd_rsp_t           exp;
    logic [`PCIE_COUNT_W-1:0] exp_count;
    int                       wait_cnt;
    wait_cnt = 0;
    exp_count = n[`PCIE_COUNT_W-1:0];
    @(negedge clk);
    rsp = in_rd_rsp(sel);
    while (!rsp.ready) begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT_CYCLES) begin
        timeout_fail("host read ready");
      end
      @(negedge clk);
      rsp = in_rd_rsp(sel);
    end
    @(posedge clk);
    drive_in_rd(sel, 1'b1, 1'b0);
    // First word shows one cycle after the FIFO takes activate
    @(posedge clk);
    drive_in_rd(sel, 1'b1, 1'b1);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      exp.ready = 1'b0;
      exp.count = exp_count;
      exp.data  = exp_words.pop_front();
      check_rd_rsp(in_rd_rsp(sel), exp, "host read");
      @(posedge clk);
    end
    drive_in_rd(sel, 1'b0, 1'b0);
  endtask

  task automatic write_buffer(input logic sel, input int n);
    ppfifo_wr_rsp_t rsp;
    ppfifo_wr_req_t req;
    logic [31:0]    word;
    int             wait_cnt;
    wait_cnt = 0;
    @(negedge clk);
    rsp = out_wr_rsp(sel);
    while (rsp.ready == 2'b00) begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT_CYCLES) begin
        timeout_fail("host write ready");
      end
      @(negedge clk);
      rsp = out_wr_rsp(sel);
    end
    if (n > int'(rsp.size)) begin
      $display("Packet of %0d words does not fit a buffer of %0d words", n, rsp.size);
      abort_run();
    end
    req.activate = rsp.ready[0] ? 2'b01 : 2'b10;
    req.stb      = 1'b0;
    req.data     = '0;
    @(posedge clk);
    drive_out_wr(sel, req);
    for (int i = 0; i < n; i++) begin
      word = next_random();
      exp_words.push_back(word);
      req.stb  = 1'b1;
      req.data = word;
      @(posedge clk);
      drive_out_wr(sel, req);
    end
    // Dropping activate commits the buffer
    @(posedge clk);
    drive_out_wr(sel, '0);
  endtask

  task automatic receive_packet(input int n, input logic bp);
    axis_beat_t  exp;
    logic [31:0] rnd;
    int          got;
    int          wait_cnt;
    got = 0;
    wait_cnt = 0;
    while (got < n) begin
      @(posedge clk);
      if (bp) begin
        rnd = next_random();
        tx_ready <= rnd[0];
      end else begin
        tx_ready <= 1'b1;
      end
      @(negedge clk);
      if (tx_valid && tx_ready) begin
        exp.data = exp_words.pop_front();
        exp.keep = '1;
        exp.last = (got == n - 1);
        check_beat(tx_beat, exp, "transmit");
        got++;
        wait_cnt = 0;
      end else begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT_CYCLES) begin
          timeout_fail("transmit beat");
        end
      end
    end
    // No repeated word after the final beat
    @(posedge clk);
    tx_ready <= 1'b0;
    @(negedge clk);
    check_bit(tx_valid, 1'b0, "transmit valid after last beat");
  endtask

  task automatic run_vector(input vector_t v);
    int remaining;
    int depth;
    int chunk;
    @(posedge clk);
    function_sel <= v.sel;
    if (v.dir == DIR_INGRESS) begin
      watch_sel   = v.sel;
      watch_quiet = 1'b1;
      send_packet(v.len);
      depth = (v.sel == `CONTROL_FUNCTION_ID) ? CTL_DEPTH : DAT_DEPTH;
      remaining = v.len;
      // Long packets split into full buffers and a remainder
      while (remaining > 0) begin
        chunk = (remaining < depth) ? remaining : depth;
        read_buffer(v.sel, chunk);
        remaining = remaining - chunk;
      end
      watch_quiet = 1'b0;
    end else begin
      write_buffer(v.sel, v.len);
      receive_packet(v.len, v.bp);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    function_sel = `CONTROL_FUNCTION_ID;
    rx_valid     = 1'b0;
    rx_beat      = '0;
    tx_ready     = 1'b0;
    cmd_in_rd    = '0;
    cmd_out_wr   = '0;
    data_in_rd   = '0;
    data_out_wr  = '0;
    rng_state    = 32'd76;
    watch_quiet  = 1'b0;
    watch_sel    = 1'b0;
    load_vectors();

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_bit(tx_valid, 1'b0, "transmit valid after reset");
    check_bit(rx_ready, 1'b0, "receive ready after reset");
    check_bit(cmd_in_rsp.ready, 1'b0, "command-in read ready after reset");
    check_bit(data_in_rsp.ready, 1'b0, "data-in read ready after reset");
    check_wr_ready(cmd_out_rsp.ready, 2'b11, "command-out write ready after reset");
    check_wr_ready(data_out_rsp.ready, 2'b11, "data-out write ready after reset");
    check_wr_size(cmd_out_rsp.size, `PCIE_COUNT_W'(CTL_DEPTH), "command-out buffer size");
    check_wr_size(data_out_rsp.size, `PCIE_COUNT_W'(DAT_DEPTH), "data-out buffer size");

    for (int r = 0; r < NUM_VECTORS; r++) begin
      run_vector(vectors[r]);
    end

    @(posedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
+incdir+tests
common/pcie_user_pkg.sv
ppfifo/ppfifo.sv
hdl/axis_to_ppfifo.sv
hdl/ppfifo_to_axis.sv
hdl/function_steer.sv
hdl/pcie_user_interface.sv
tests/tb_pcie_user_interface.sv
